/* rtl/opll_pkg.sv */
/*
 * Shared types, counts and register addresses of the OPLL register front end.
 * Imported by wildcard in every RTL module that needs them.
 */
package opll_pkg;

    // Widths with a meaning
    typedef logic [8:0]  fnum_t;     // Frequency number
    typedef logic [2:0]  block_t;    // Octave
    typedef logic [3:0]  inst_t;     // Instrument, 0 = user patch
    typedef logic [3:0]  vol_t;      // Channel attenuation
    typedef logic [3:0]  rate_t;     // AR/DR/RR and sustain level
    typedef logic [5:0]  tl_t;       // Total level
    typedef logic [63:0] patch_t;    // Eight bytes, byte 0 in the low bits
    typedef logic [17:0] slot_vec_t; // One-hot slot marker

    // Channel and slot counts
    localparam int NUM_CH   = 9;
    localparam int NUM_SLOT = 18;   // Two operators per channel

    // Rhythm key-on and enable
    localparam logic [7:0] REG_RHYTHM = 8'h0E;

    // Channel register groups, matched on the high nibble
    localparam logic [3:0] REG_FNUM_LO = 4'h1;
    localparam logic [3:0] REG_FNUM_HI = 4'h2; // {sus, keyon, block, fnum[8]}
    localparam logic [3:0] REG_INST    = 4'h3; // {inst, vol}

endpackage

/* rtl/opll_upd_if.sv */
/*
 * Register update bundle from the write decoder to the channel register bank.
 * Strobes last one clk, rhythm fields are levels.
 */
`timescale 1ns/1ns

interface opll_upd_if;

    logic [7:0] data;       // Copy of the last data write
    logic [1:0] sel_group;  // Channel / 3
    logic [1:0] sel_sub;    // Channel % 3
    logic [2:0] user_idx;   // User patch byte
    logic       up_user;
    logic       up_fnumlo;
    logic       up_fnumhi;
    logic       up_inst;
    logic       rhy_en;     // Rhythm mode
    logic [4:0] rhy_kon;    // BD, SD, TOM, CYM, HH order of reg 0x0E

    // Decoder side
    modport mmr (
        output data, sel_group, sel_sub, user_idx,
        output up_user, up_fnumlo, up_fnumhi, up_inst,
        output rhy_en, rhy_kon
    );

    // Register bank side
    modport bank (
        input data, sel_group, sel_sub, user_idx,
        input up_user, up_fnumlo, up_fnumhi, up_inst,
        input rhy_en, rhy_kon
    );

endinterface

/* rtl/opll_cen_div.sv */
/*
 * Operator clock enable. Counts cen pulses and raises cenop for one clk
 * on every CEN_DIV-th of them.
 */
`timescale 1ns/1ns

module opll_cen_div #(
    parameter int CEN_DIV = 4   // cen pulses per cenop
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cenop
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(CEN_DIV - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen) begin
            cnt <= (cnt == LAST) ? '0 : cnt + 1'b1; // Wrap counter
        end
    end

    // Pulse on the wrapping cen
    assign cenop = cen && (cnt == LAST);

    // Counter leaves LAST right after the pulse
    a_cenop_single: assert property (@(posedge clk) disable iff (rst)
        cenop |=> !cenop)
        else $error("cenop longer than one clk");

endmodule

/* rtl/opll_mmr.sv */
/*
 * CPU port decoder. An address write selects a register, a data write
 * turns into one update strobe on the bundle one clk later, plus the
 * rhythm register which is kept here.
 */
`timescale 1ns/1ns

module opll_mmr import opll_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       write,
    input  logic       addr,    // Low selects, high writes data
    input  logic [7:0] din,
    opll_upd_if.mmr    upd
);

    logic [7:0] selreg;     // Selected register
    logic [3:0] ch_num;
    logic       ch_ok;      // Channel 0..8
    logic       data_wr;
    logic [1:0] grp;
    logic [1:0] sub;

    assign ch_num  = selreg[3:0];
    assign ch_ok   = ch_num <= 4'd8;
    assign data_wr = write && addr;

    // Channel to group and sub-index
    always_comb begin
        if (ch_num < 4'd3) begin
            grp = 2'd0;
            sub = ch_num[1:0];
        end else if (ch_num < 4'd6) begin
            grp = 2'd1;
            sub = 2'(ch_num - 4'd3);
        end else begin
            grp = 2'd2;
            sub = 2'(ch_num - 4'd6);   // Channel 8 at most, see ch_ok
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            selreg        <= '0;
            upd.up_user   <= 1'b0;
            upd.up_fnumlo <= 1'b0;
            upd.up_fnumhi <= 1'b0;
            upd.up_inst   <= 1'b0;
            upd.rhy_en    <= 1'b0;
            upd.rhy_kon   <= '0;
        end else begin
            // Strobes last a single clk
            upd.up_user   <= 1'b0;
            upd.up_fnumlo <= 1'b0;
            upd.up_fnumhi <= 1'b0;
            upd.up_inst   <= 1'b0;
            if (write && !addr) begin
                selreg <= din;
            end
            if (data_wr) begin
                upd.up_user   <= selreg[7:3] == 5'd0;            // 0x00-0x07
                upd.up_fnumlo <= ch_ok && selreg[7:4] == REG_FNUM_LO;
                upd.up_fnumhi <= ch_ok && selreg[7:4] == REG_FNUM_HI;
                upd.up_inst   <= ch_ok && selreg[7:4] == REG_INST;
                if (selreg == REG_RHYTHM) begin
                    upd.rhy_en  <= din[5];
                    upd.rhy_kon <= din[4:0];
                end
            end
        end
    end

    // Payload, only read while a strobe is high
    always_ff @(posedge clk) begin
        if (data_wr) begin
            upd.data      <= din;
            upd.sel_group <= grp;
            upd.sel_sub   <= sub;
            upd.user_idx  <= selreg[2:0];
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({upd.up_user, upd.up_fnumlo, upd.up_fnumhi, upd.up_inst}))
        else $error("more than one update strobe");

endmodule

/* rtl/opll_patch_mem.sv */
/*
 * Instrument storage. Instrument 0 is the user patch written through
 * registers 0x00-0x07, 1..15 are presets loaded through the prog port.
 * The full patch of rd_inst is returned without a clock.
 */
`timescale 1ns/1ns

module opll_patch_mem import opll_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       user_we,
    input  logic [2:0] user_idx,
    input  logic [7:0] user_data,
    input  logic [6:0] prog_addr,   // {instrument, byte}
    input  logic [7:0] prog_data,
    input  logic       prog_we,
    input  inst_t      rd_inst,
    output patch_t     rd_patch
);

    patch_t user_patch;
    patch_t preset_mem [1:15];

    inst_t      prog_inst;
    logic [2:0] prog_byte;

    assign prog_inst = prog_addr[6:3];
    assign prog_byte = prog_addr[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            user_patch <= '0;
        end else if (user_we) begin
            user_patch[{user_idx, 3'b000} +: 8] <= user_data;
        end
    end

    // Instrument 0 is never touched from this port
    always_ff @(posedge clk) begin
        if (prog_we && prog_inst != 4'd0) begin
            preset_mem[prog_inst][{prog_byte, 3'b000} +: 8] <= prog_data;
        end
    end

    always_comb begin
        if (rd_inst == 4'd0) begin
            rd_patch = user_patch;
        end else begin
            rd_patch = preset_mem[rd_inst];
        end
    end

endmodule

/* rtl/opll_reg_bank.sv */
/*
 * Channel registers and slot sequencer. Each cenop moves to the next of the
 * 18 slots and registers that slot's parameters, so every output belongs to
 * the slot marked on the same cycle.
 */
`timescale 1ns/1ns

module opll_reg_bank import opll_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cenop,
    opll_upd_if.bank   upd,
    output inst_t      rd_inst,
    input  patch_t     rd_patch,
    output logic       zero,
    output slot_vec_t  slot,
    output fnum_t      fnum,
    output block_t     block,
    output logic       keyon,
    output logic       sus,
    output logic       amen,
    output logic       viben,
    output logic       en_sus,
    output logic       ks,
    output logic       wavsel,
    output logic [3:0] mul,
    output rate_t      arate,
    output rate_t      drate,
    output rate_t      rrate,
    output rate_t      sl,
    output logic [1:0] ksl,
    output tl_t        tl,
    output logic [2:0] fb,
    output vol_t       vol,
    output logic       rhy_en
);

    localparam int SW = $clog2(NUM_SLOT);

    // Per-channel storage
    fnum_t  fnum_r  [NUM_CH];
    block_t block_r [NUM_CH];
    logic   keyon_r [NUM_CH];
    logic   sus_r   [NUM_CH];
    inst_t  inst_r  [NUM_CH];
    vol_t   vol_r   [NUM_CH];

    logic [SW-1:0] slot_cnt;    // Slot on display
    logic [SW-1:0] nxt_slot;
    logic [3:0]    nxt_ch;
    logic          nxt_op;      // 1 for carrier
    logic [3:0]    up_ch;
    logic [7:0]    op_byte;     // {am, vib, egtype, ks, mul}
    logic [7:0]    ksl_tl_b;
    logic [7:0]    misc_b;      // {ksl car, -, wave car, wave mod, fb}
    logic [7:0]    eg_ad;
    logic [7:0]    eg_sr;
    logic          rhy_key;

    assign up_ch = 4'(upd.sel_group) * 4'd3 + 4'(upd.sel_sub);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                fnum_r[i]  <= '0;
                block_r[i] <= '0;
                keyon_r[i] <= 1'b0;
                sus_r[i]   <= 1'b0;
                inst_r[i]  <= '0;
                vol_r[i]   <= '0;
            end
        end else begin
            if (upd.up_fnumlo) fnum_r[up_ch][7:0] <= upd.data;
            if (upd.up_fnumhi) begin
                {sus_r[up_ch], keyon_r[up_ch], block_r[up_ch], fnum_r[up_ch][8]}
                    <= upd.data[5:0];
            end
            if (upd.up_inst) {inst_r[up_ch], vol_r[up_ch]} <= upd.data;
        end
    end

    assign nxt_slot = (slot_cnt == SW'(NUM_SLOT - 1)) ? '0 : slot_cnt + 1'b1;
    assign nxt_ch   = nxt_slot[SW-1:1];
    assign nxt_op   = nxt_slot[0];
    assign rd_inst  = inst_r[nxt_ch];   // Patch of the upcoming channel

    // Operator field pick
    assign op_byte  = nxt_op ? rd_patch[15:8]  : rd_patch[7:0];
    assign ksl_tl_b = rd_patch[23:16];
    assign misc_b   = rd_patch[31:24];
    assign eg_ad    = nxt_op ? rd_patch[47:40] : rd_patch[39:32];
    assign eg_sr    = nxt_op ? rd_patch[63:56] : rd_patch[55:48];

    // Rhythm key-on per slot, BD takes both operators
    always_comb begin
        rhy_key = 1'b0;
        case (nxt_slot)
            5'd12, 5'd13: rhy_key = upd.rhy_kon[4];   // BD
            5'd14:        rhy_key = upd.rhy_kon[0];   // HH
            5'd15:        rhy_key = upd.rhy_kon[3];   // SD
            5'd16:        rhy_key = upd.rhy_kon[2];   // TOM
            5'd17:        rhy_key = upd.rhy_kon[1];   // CYM
            default:      rhy_key = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= SW'(NUM_SLOT - 1);  // First cenop shows slot 0
            slot     <= '0;
            zero     <= 1'b0;
        end else if (cenop) begin
            slot_cnt <= nxt_slot;
            slot     <= slot_vec_t'(1) << nxt_slot;
            zero     <= nxt_slot == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cenop) begin
            fnum   <= fnum_r[nxt_ch];
            block  <= block_r[nxt_ch];
            sus    <= sus_r[nxt_ch];
            vol    <= vol_r[nxt_ch];
            keyon  <= keyon_r[nxt_ch] | (upd.rhy_en & rhy_key);
            {amen, viben, en_sus, ks, mul} <= op_byte;
            {arate, drate} <= eg_ad;
            {sl, rrate}    <= eg_sr;
            ksl    <= nxt_op ? misc_b[7:6] : ksl_tl_b[7:6];
            tl     <= nxt_op ? {vol_r[nxt_ch], 2'b00} : ksl_tl_b[5:0]; // Carrier by volume
            wavsel <= nxt_op ? misc_b[4] : misc_b[3];
            fb     <= misc_b[2:0];
        end
    end

    assign rhy_en = upd.rhy_en;

    // Empty marker only until the first cenop
    a_slot_marker: assert property (@(posedge clk) disable iff (rst)
        $onehot0(slot) and ((|slot) |=> $onehot(slot)))
        else $error("slot marker not one-hot");

endmodule

/* rtl/opll_regs_top.sv */
/*
 * OPLL register front end. CPU port and preset programming port in,
 * per-slot parameters for the sound generators out.
 */
`timescale 1ns/1ns

module opll_regs_top import opll_pkg::*; #(
    parameter int CEN_DIV = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       write,
    input  logic       addr,
    input  logic [7:0] din,
    input  logic [6:0] prog_addr,
    input  logic [7:0] prog_data,
    input  logic       prog_we,
    output logic       cenop,
    output logic       zero,
    output slot_vec_t  slot,
    output fnum_t      fnum,
    output block_t     block,
    output logic       keyon,
    output logic       sus,
    output logic       amen,
    output logic       viben,
    output logic       en_sus,
    output logic       ks,
    output logic       wavsel,
    output logic [3:0] mul,
    output rate_t      arate,
    output rate_t      drate,
    output rate_t      rrate,
    output rate_t      sl,
    output logic [1:0] ksl,
    output tl_t        tl,
    output logic [2:0] fb,
    output vol_t       vol,
    output logic       rhy_en
);

    opll_upd_if upd ();

    inst_t  rd_inst;
    patch_t rd_patch;

    opll_cen_div #(.CEN_DIV(CEN_DIV)) u_div (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cenop (cenop)
    );

    opll_mmr u_mmr (
        .clk   (clk),
        .rst   (rst),
        .write (write),
        .addr  (addr),
        .din   (din),
        .upd   (upd.mmr)
    );

    // User bytes come straight off the update bundle
    opll_patch_mem u_patch (
        .clk       (clk),
        .rst       (rst),
        .user_we   (upd.up_user),
        .user_idx  (upd.user_idx),
        .user_data (upd.data),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .rd_inst   (rd_inst),
        .rd_patch  (rd_patch)
    );

    opll_reg_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .cenop    (cenop),
        .upd      (upd.bank),
        .rd_inst  (rd_inst),
        .rd_patch (rd_patch),
        .zero     (zero),
        .slot     (slot),
        .fnum     (fnum),
        .block    (block),
        .keyon    (keyon),
        .sus      (sus),
        .amen     (amen),
        .viben    (viben),
        .en_sus   (en_sus),
        .ks       (ks),
        .wavsel   (wavsel),
        .mul      (mul),
        .arate    (arate),
        .drate    (drate),
        .rrate    (rrate),
        .sl       (sl),
        .ksl      (ksl),
        .tl       (tl),
        .fb       (fb),
        .vol      (vol),
        .rhy_en   (rhy_en)
    );

endmodule

/* sim/opll_regs_tb.sv */
/*
 * Testbench for the OPLL register front end. Runs a table of port writes,
 * preset loads and slot sweeps against a register model, then counts cenop.
 */
`timescale 1ns/1ns

module opll_regs_tb import opll_pkg::*;;

    localparam int CEN_DIV = 4;

    typedef struct packed {
        fnum_t      fnum;
        block_t     block;
        logic       keyon;
        logic       sus;
        logic [7:0] op_b;       // {am, vib, egtype, ks, mul}
        logic [7:0] ad_b;       // {ar, dr}
        logic [7:0] sr_b;       // {sl, rr}
        logic [1:0] ksl;
        tl_t        tl;
        logic       wavsel;
        logic [2:0] fb;
        vol_t       vol;
    } slot_exp_t;

    logic clk, rst, cen, write, addr, prog_we;
    logic [7:0] din, prog_data;
    logic [6:0] prog_addr;
    logic cenop, zero, keyon, sus, amen, viben, en_sus, ks, wavsel, rhy_en;
    slot_vec_t slot;
    fnum_t fnum;
    block_t block;
    logic [3:0] mul;
    rate_t arate, drate, rrate, sl;
    logic [1:0] ksl;
    tl_t tl;
    logic [2:0] fb;
    vol_t vol;

    // Register model
    fnum_t      fnum_m [NUM_CH];
    logic [5:0] hi_m   [NUM_CH];    // {sus, keyon, block, fnum[8]}
    logic [7:0] iv_m   [NUM_CH];    // {inst, vol}
    logic [7:0] patch_m [16][8];    // Entry 0 is the user patch
    logic       rhy_en_m;
    logic [4:0] rhy_kon_m;
    slot_exp_t  exp_tab [NUM_SLOT];
    logic [17:0] wr_tab [$];        // {kind, addr, data}, kind 1 sweep, 2 prog inst 0
    logic [31:0] seed_val;

    opll_regs_top #(.CEN_DIV(CEN_DIV)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic port_write(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        write <= 1'b1;
        addr  <= 1'b0;          // Select register
        din   <= a;
        @(posedge clk);
        write <= 1'b0;
        @(posedge clk);
        write <= 1'b1;
        addr  <= 1'b1;          // Data
        din   <= d;
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic prog_write(input logic [3:0] inst, input logic [2:0] b, input logic [7:0] d);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= {inst, b};
        prog_data <= d;
        if (inst != 4'd0) patch_m[inst][b] = d;   // Instrument 0 not reachable here
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Register rules of the CPU port
    function automatic void model_write(input logic [7:0] a, input logic [7:0] d);
        int ch;
        ch = int'(a[3:0]);
        if (a <= 8'h07) begin
            patch_m[0][a[2:0]] = d;
        end else if (a == 8'h0E) begin
            rhy_en_m  = d[5];
            rhy_kon_m = d[4:0];
        end else if (ch <= 8) begin
            case (a[7:4])
                4'h1: fnum_m[ch][7:0] = d;
                4'h2: hi_m[ch] = d[5:0];
                4'h3: iv_m[ch] = d;
                default: ;      // Unused address
            endcase
        end
    endfunction

    // Rhythm bit per slot, -1 where none
    function automatic int rhythm_bit(input int s);
        case (s)
            12, 13:  return 4;
            14:      return 0;
            15:      return 3;
            16:      return 2;
            17:      return 1;
            default: return -1;
        endcase
    endfunction

    function automatic void build_expected();
        int ch, op, rb;
        logic [3:0] inst;
        for (int s = 0; s < NUM_SLOT; s++) begin
            ch   = s / 2;
            op   = s % 2;
            inst = iv_m[ch][7:4];
            rb   = rhythm_bit(s);
            exp_tab[s].fnum   = {hi_m[ch][0], fnum_m[ch][7:0]};
            exp_tab[s].block  = hi_m[ch][3:1];
            exp_tab[s].sus    = hi_m[ch][5];
            exp_tab[s].keyon  = hi_m[ch][4] | (rhy_en_m && rb >= 0 && rhy_kon_m[rb]);
            exp_tab[s].vol    = iv_m[ch][3:0];
            exp_tab[s].op_b   = patch_m[inst][op];
            exp_tab[s].ad_b   = patch_m[inst][4 + op];
            exp_tab[s].sr_b   = patch_m[inst][6 + op];
            exp_tab[s].ksl    = op ? patch_m[inst][3][7:6] : patch_m[inst][2][7:6];
            exp_tab[s].tl     = op ? {iv_m[ch][3:0], 2'b00} : patch_m[inst][2][5:0];
            exp_tab[s].wavsel = op ? patch_m[inst][3][4] : patch_m[inst][3][3];
            exp_tab[s].fb     = patch_m[inst][3][2:0];
        end
    endfunction

    task automatic wait_slot(input int s, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (slot !== (slot_vec_t'(1) << s)) begin
            if (n == limit) begin
                $display("timeout: slot %0d never appeared on the slot output", s);
                $display("Result: FAILED");
                $fatal(1, "slot timeout");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic compare_slot(input int s);
        string t;
        t = $sformatf("slot %0d", s);
        check_val({t, " zero"}, 16'(zero), 16'(s == 0));
        check_val({t, " fnum"}, 16'(fnum), 16'(exp_tab[s].fnum));
        check_val({t, " block"}, 16'(block), 16'(exp_tab[s].block));
        check_val({t, " keyon"}, 16'(keyon), 16'(exp_tab[s].keyon));
        check_val({t, " sus"}, 16'(sus), 16'(exp_tab[s].sus));
        check_val({t, " vol"}, 16'(vol), 16'(exp_tab[s].vol));
        check_val({t, " am/vib/egtype/ks/mul"}, 16'({amen, viben, en_sus, ks, mul}),
                  16'(exp_tab[s].op_b));
        check_val({t, " ar/dr"}, 16'({arate, drate}), 16'(exp_tab[s].ad_b));
        check_val({t, " sl/rr"}, 16'({sl, rrate}), 16'(exp_tab[s].sr_b));
        check_val({t, " ksl"}, 16'(ksl), 16'(exp_tab[s].ksl));
        check_val({t, " tl"}, 16'(tl), 16'(exp_tab[s].tl));
        check_val({t, " wavsel"}, 16'(wavsel), 16'(exp_tab[s].wavsel));
        check_val({t, " fb"}, 16'(fb), 16'(exp_tab[s].fb));
        check_val({t, " rhy_en"}, 16'(rhy_en), 16'(rhy_en_m));
    endtask

    // One full pass over the slots, optionally starting at a fresh slot 0
    task automatic sweep_slots(input bit sync);
        build_expected();
        if (sync) begin
            repeat (3) @(posedge clk);      // Let the last update settle
            wait_slot(NUM_SLOT - 1, 20 * CEN_DIV);
        end
        for (int s = 0; s < NUM_SLOT; s++) begin
            wait_slot(s, 3 * CEN_DIV);      // Consecutive cenops only
            compare_slot(s);
        end
    endtask

    task automatic add_entry(input logic [1:0] kind, input logic [7:0] a, input logic [7:0] d);
        wr_tab.push_back({kind, a, d});
    endtask

    task automatic fill_table();
        logic [3:0] ch;
        logic [7:0] unused [12] = '{8'h19, 8'h1C, 8'h1F, 8'h29, 8'h2F, 8'h3A,
                                    8'h3F, 8'h08, 8'h0F, 8'h40, 8'h55, 8'hFF};
        for (int i = 0; i < 6; i++) begin     // Channel registers
            ch = 4'($urandom % NUM_CH);
            add_entry(2'd0, {4'h1, ch}, 8'($urandom));
            add_entry(2'd0, {4'h2, ch}, 8'($urandom));
            add_entry(2'd0, {4'h3, ch}, {4'(1 + $urandom % 15), 4'($urandom)});
        end
        foreach (unused[i]) add_entry(2'd0, unused[i], 8'($urandom));
        add_entry(2'd1, 8'h00, 8'h00);
        for (int b = 0; b < 8; b++) add_entry(2'd0, 8'(b), 8'($urandom));  // User patch
        add_entry(2'd0, 8'h30, {4'd0, 4'($urandom)});
        add_entry(2'd0, 8'h35, {4'd0, 4'($urandom)});
        for (int b = 0; b < 8; b++) add_entry(2'd2, 8'(b), 8'($urandom));
        add_entry(2'd1, 8'h00, 8'h00);
        for (int c = 6; c < 9; c++) add_entry(2'd0, 8'h20 + 8'(c), 8'($urandom) & 8'h2F);
        for (int b = 0; b < 5; b++) begin     // One rhythm bit at a time
            add_entry(2'd0, 8'h0E, 8'h20 | (8'h01 << b));
            add_entry(2'd1, 8'h00, 8'h00);
        end
        add_entry(2'd0, 8'h0E, 8'h1F);        // Rhythm bits without rhy_en
        add_entry(2'd1, 8'h00, 8'h00);
    endtask

    task automatic count_cenop();
        int pulses;
        pulses = 0;
        repeat (72) begin
            @(negedge clk);
            if (cenop) pulses++;
        end
        check_val("cenop pulses in 72 cycles", 16'(pulses), 16'(72 / CEN_DIV));
    endtask

    initial begin
        seed_val  = $urandom(74891);
        rst       = 1'b1;
        cen       = 1'b1;
        write     = 1'b0;
        addr      = 1'b0;
        din       = '0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rhy_en_m  = 1'b0;
        rhy_kon_m = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            fnum_m[c] = '0;
            hi_m[c]   = '0;
            iv_m[c]   = '0;
        end
        for (int i = 0; i < 8; i++) patch_m[0][i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("slot after reset", 32'(slot), 32'h0000);
        check_val("zero after reset", 16'(zero), 16'h0000);
        sweep_slots(1'b0);                    // Reset state, in order from slot 0
        for (int i = 1; i < 16; i++) begin
            for (int b = 0; b < 8; b++) prog_write(4'(i), 3'(b), 8'($urandom));
        end
        fill_table();
        foreach (wr_tab[i]) begin
            case (wr_tab[i][17:16])
                2'd0: begin
                    port_write(wr_tab[i][15:8], wr_tab[i][7:0]);
                    model_write(wr_tab[i][15:8], wr_tab[i][7:0]);
                end
                2'd1: sweep_slots(1'b1);
                default: prog_write(4'd0, wr_tab[i][10:8], wr_tab[i][7:0]);
            endcase
        end
        count_cenop();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* opll_regs.f */
rtl/opll_pkg.sv
rtl/opll_upd_if.sv
rtl/opll_cen_div.sv
rtl/opll_mmr.sv
rtl/opll_patch_mem.sv
rtl/opll_reg_bank.sv
rtl/opll_regs_top.sv
sim/opll_regs_tb.sv

/* Bender.yml */
package:
  name: opll_regs

sources:
  - rtl/opll_pkg.sv
  - rtl/opll_upd_if.sv
  - rtl/opll_cen_div.sv
  - rtl/opll_mmr.sv
  - rtl/opll_patch_mem.sv
  - rtl/opll_reg_bank.sv
  - rtl/opll_regs_top.sv
  - target: simulation
    files:
      - sim/opll_regs_tb.sv
